/* common/ddr_sdram_params.svh */
`ifndef DDR_SDRAM_PARAMS_SVH
`define DDR_SDRAM_PARAMS_SVH

// SDRAM geometry for one x16 device
`define DDR_BA_WIDTH   2
`define DDR_ROW_WIDTH  13
`define DDR_COL_WIDTH  9
`define DDR_DQ_WIDTH   16

// Timing in controller clock cycles
`define DDR_T_RCD      2
`define DDR_CAS_LAT    2
`define DDR_T_RP       2
`define DDR_T_RFC      8
`define DDR_T_WR       2

// Cycles between two auto-refresh commands
`define DDR_REFRESH_INTERVAL 200

`endif

/* common/ddr_sdram_pkg.sv */
`include "ddr_sdram_params.svh"

package ddr_sdram_pkg;

	// Values are the {RAS#, CAS#, WE#} pin levels
	typedef enum logic [2:0] {
		NOP       = 3'b111,
		ACTIVE    = 3'b011,
		READ      = 3'b101,
		WRITE     = 3'b100,
		PRECHARGE = 3'b010,
		REFRESH   = 3'b001
	} ddr_cmd_e;

	// One cycle of command pins, cs is the active-low pin level
	typedef struct packed {
		logic                      cke;
		logic                      cs;
		ddr_cmd_e                  cmd;
		logic [`DDR_BA_WIDTH-1:0]  ba;
		logic [`DDR_ROW_WIDTH-1:0] addr;
	} ddr_cmd_t;

	typedef enum logic [3:0] {
		S_IDLE,
		S_ACTIVATE,
		S_RCD_WAIT,
		S_READ,
		S_WRITE,
		S_CAS_WAIT,
		S_CAPTURE,
		S_WR_RECOVER,
		S_PRE_WAIT,
		S_REFRESH
	} ctrl_state_e;

endpackage

/* common/host_pkg.sv */
`include "ddr_sdram_params.svh"

package host_pkg;

	// Word address as seen by a host port
	typedef struct packed {
		logic [`DDR_BA_WIDTH-1:0]  bank;
		logic [`DDR_ROW_WIDTH-1:0] row;
		logic [`DDR_COL_WIDTH-1:0] col;
	} host_addr_t;

	typedef struct packed {
		logic        wr;
		host_addr_t  addr;
		logic [31:0] wdata;
	} host_req_t;

	typedef enum logic {
		PORT0 = 1'b0,
		PORT1 = 1'b1
	} port_sel_e;

	// Completion of one access
	typedef struct packed {
		logic        done;
		logic        rd_valid;
		logic [31:0] rd_data;
	} host_rsp_t;

endpackage

/* hw/host_arbiter.sv */
`timescale 1ns/10ps

module host_arbiter (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_req0,
	input  logic                i_req1,
	input  host_pkg::host_req_t i_req_data0,
	input  host_pkg::host_req_t i_req_data1,
	input  logic                i_ready,
	input  logic                i_done,
	output logic                o_start,
	output host_pkg::host_req_t o_req,
	output host_pkg::port_sel_e o_port
);
	import host_pkg::*;

	logic      busy;
	logic      grant;
	port_sel_e pick;

	assign grant = !busy && i_ready && (i_req0 || i_req1);

	// On a tie the port that did not win last time goes first
	always_comb begin
		if (i_req0 && i_req1) begin
			pick = (o_port == PORT0) ? PORT1 : PORT0;
		end else if (i_req1) begin
			pick = PORT1;
		end else begin
			pick = PORT0;
		end
	end

	// o_port doubles as the last-winner register
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			busy    <= 1'b0;
			o_start <= 1'b0;
			o_port  <= PORT1;
		end else begin
			o_start <= grant;
			if (grant) begin
				busy   <= 1'b1;
				o_port <= pick;
			end else if (i_done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (grant) begin
			o_req <= (pick == PORT1) ? i_req_data1 : i_req_data0;
		end
	end

	// Controller completes only the one access that is outstanding
	a_done_while_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		i_done |-> busy)
		else $error("controller done without an outstanding access");

endmodule

/* ddr_sdram/ddr_sdram_ctrl.sv */
`timescale 1ns/10ps
`include "ddr_sdram_params.svh"

module ddr_sdram_ctrl (
	input  logic                      i_clk,
	input  logic                      i_reset,
	input  logic                      i_start,
	input  host_pkg::host_req_t       i_req,
	output logic                      o_ready,
	output logic                      o_done,
	output logic                      o_rd_valid,
	output logic [31:0]               o_rd_data,
	output ddr_sdram_pkg::ddr_cmd_t   o_cmd,
	output logic                      o_dq_write_next_en,
	output logic                      o_dqs_write_next_en,
	output logic [`DDR_DQ_WIDTH-1:0]  o_dq_write_even,
	output logic [`DDR_DQ_WIDTH-1:0]  o_dq_write_odd,
	input  logic [`DDR_DQ_WIDTH-1:0]  i_dq_read_even,
	input  logic [`DDR_DQ_WIDTH-1:0]  i_dq_read_odd
);
	import ddr_sdram_pkg::*;
	import host_pkg::*;

	localparam int AP_BIT = 10;
	localparam int CNT_W  = 4;
	localparam int REF_W  = $clog2(`DDR_REFRESH_INTERVAL);

	ctrl_state_e               state;
	logic [CNT_W-1:0]          wait_cnt;
	logic [REF_W-1:0]          ref_cnt;
	logic                      ref_tick;
	logic                      ref_pending;
	host_req_t                 req_q;
	logic [`DDR_ROW_WIDTH-1:0] col_addr;

	function automatic ddr_cmd_t make_cmd(ddr_cmd_e c, logic [`DDR_BA_WIDTH-1:0] ba,
	                                      logic [`DDR_ROW_WIDTH-1:0] addr);
		ddr_cmd_t w;
		w.cke  = 1'b1;
		w.cs   = 1'b0;
		w.cmd  = c;
		w.ba   = ba;
		w.addr = addr;
		return w;
	endfunction

	// --------------------------------------------------
	// Refresh timer
	// --------------------------------------------------
	assign ref_tick = (ref_cnt == '0);

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			ref_cnt     <= REF_W'(`DDR_REFRESH_INTERVAL - 1);
			ref_pending <= 1'b0;
		end else begin
			ref_cnt <= ref_tick ? REF_W'(`DDR_REFRESH_INTERVAL - 1) : ref_cnt - 1'b1;
			if (ref_tick) begin
				ref_pending <= 1'b1;
			end else if (state == S_IDLE && ref_pending) begin
				ref_pending <= 1'b0;
			end
		end
	end

	// Drop ready one cycle early so a grant never meets a fresh refresh
	assign o_ready = (state == S_IDLE) && !ref_pending && !ref_tick;

	// Column with A10 set for auto-precharge
	always_comb begin
		col_addr = '0;
		col_addr[`DDR_COL_WIDTH-1:0] = req_q.addr.col;
		col_addr[AP_BIT] = 1'b1;
	end

	assign o_dq_write_even = req_q.wdata[`DDR_DQ_WIDTH-1:0];
	assign o_dq_write_odd  = req_q.wdata[31:`DDR_DQ_WIDTH];

	// --------------------------------------------------
	// Command sequencer
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state               <= S_IDLE;
			wait_cnt            <= '0;
			o_cmd               <= make_cmd(NOP, '0, '0);
			o_done              <= 1'b0;
			o_rd_valid          <= 1'b0;
			o_dq_write_next_en  <= 1'b0;
			o_dqs_write_next_en <= 1'b0;
		end else begin
			o_cmd               <= make_cmd(NOP, '0, '0);
			o_done              <= 1'b0;
			o_rd_valid          <= 1'b0;
			// Data and strobe follow the WRITE through the I/O register
			o_dq_write_next_en  <= (state == S_WRITE);
			o_dqs_write_next_en <= (state == S_WRITE);
			case (state)
				S_IDLE: begin
					if (ref_pending) begin
						o_cmd    <= make_cmd(REFRESH, '0, '0);
						wait_cnt <= CNT_W'(`DDR_T_RFC - 1);
						state    <= S_REFRESH;
					end else if (i_start) begin
						o_cmd <= make_cmd(ACTIVE, i_req.addr.bank, i_req.addr.row);
						state <= S_ACTIVATE;
					end
				end
				S_ACTIVATE: begin
					// This cycle already counts toward tRCD
					wait_cnt <= CNT_W'(`DDR_T_RCD - 2);
					state    <= S_RCD_WAIT;
				end
				S_RCD_WAIT: begin
					if (wait_cnt == '0) begin
						if (req_q.wr) begin
							o_cmd <= make_cmd(WRITE, req_q.addr.bank, col_addr);
							state <= S_WRITE;
						end else begin
							o_cmd <= make_cmd(READ, req_q.addr.bank, col_addr);
							state <= S_READ;
						end
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				S_READ: begin
					// One extra cycle for the pin register
					wait_cnt <= CNT_W'(`DDR_CAS_LAT);
					state    <= S_CAS_WAIT;
				end
				S_CAS_WAIT: begin
					if (wait_cnt == '0) begin
						state <= S_CAPTURE;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				S_CAPTURE: begin
					// Auto-precharge has run out under the CAS wait
					o_rd_valid <= 1'b1;
					o_done     <= 1'b1;
					state      <= S_IDLE;
				end
				S_WRITE: begin
					wait_cnt <= CNT_W'(`DDR_T_WR - 1);
					state    <= S_WR_RECOVER;
				end
				S_WR_RECOVER: begin
					if (wait_cnt == '0) begin
						wait_cnt <= CNT_W'(`DDR_T_RP - 2);
						state    <= S_PRE_WAIT;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				S_PRE_WAIT: begin
					if (wait_cnt == '0) begin
						o_done <= 1'b1;
						state  <= S_IDLE;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				S_REFRESH: begin
					if (wait_cnt == '0) begin
						state <= S_IDLE;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && i_start) begin
			req_q <= i_req;
		end
		if (state == S_CAPTURE) begin
			o_rd_data <= {i_dq_read_odd, i_dq_read_even};
		end
	end

	a_rw_after_active: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_cmd.cmd inside {READ, WRITE}) |-> ($past(o_cmd.cmd, `DDR_T_RCD) == ACTIVE))
		else $error("READ or WRITE without ACTIVE tRCD earlier");

	// The arbiter must respect ready so a refresh never loses a start
	a_no_start_on_refresh: assert property (@(posedge i_clk) disable iff (i_reset)
		(state == S_IDLE && i_start) |-> !ref_pending)
		else $error("access started while refresh pending");

endmodule

/* ddr_sdram/ddr_sdram_io.sv */
`timescale 1ns/10ps
`include "ddr_sdram_params.svh"

module ddr_sdram_io (
	input  logic                         i_clk,
	input  logic                         i_clk90,
	input  logic                         i_reset,
	input  ddr_sdram_pkg::ddr_cmd_t      i_cmd,
	input  logic                         i_dq_write_next_en,
	input  logic                         i_dqs_write_next_en,
	input  logic [`DDR_DQ_WIDTH-1:0]     i_dq_write_even,
	input  logic [`DDR_DQ_WIDTH-1:0]     i_dq_write_odd,
	output logic [`DDR_DQ_WIDTH-1:0]     o_dq_read_even,
	output logic [`DDR_DQ_WIDTH-1:0]     o_dq_read_odd,
	output logic                         o_ddr_ck_p,
	output logic                         o_ddr_ck_n,
	output logic                         o_ddr_cke,
	output logic                         o_ddr_cs,
	output logic                         o_ddr_ras,
	output logic                         o_ddr_cas,
	output logic                         o_ddr_we,
	output logic [`DDR_BA_WIDTH-1:0]     o_ddr_ba,
	output logic [`DDR_ROW_WIDTH-1:0]    o_ddr_a,
	output logic [`DDR_DQ_WIDTH/8-1:0]   o_ddr_dm,
	inout  wire  [`DDR_DQ_WIDTH-1:0]     io_ddr_dq,
	inout  wire  [`DDR_DQ_WIDTH/8-1:0]   io_ddr_dqs
);
	import ddr_sdram_pkg::*;

	localparam int DQS_W = `DDR_DQ_WIDTH / 8;

	ddr_cmd_t                 cmd_q;
	logic                     dq_oe;
	logic                     dqs_oe;
	logic [`DDR_DQ_WIDTH-1:0] dq_even_q;
	logic [`DDR_DQ_WIDTH-1:0] dq_odd_q;
	logic [`DDR_DQ_WIDTH-1:0] dq_out;
	logic [`DDR_DQ_WIDTH-1:0] rd_even_neg;

	// --------------------------------------------------
	// Clock pair and command pins
	// --------------------------------------------------
	assign o_ddr_ck_p = i_clk;
	assign o_ddr_ck_n = ~i_clk;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			cmd_q.cke  <= 1'b1;
			cmd_q.cs   <= 1'b0;
			cmd_q.cmd  <= NOP;
			cmd_q.ba   <= '0;
			cmd_q.addr <= '0;
		end else begin
			cmd_q <= i_cmd;
		end
	end

	assign o_ddr_cke = cmd_q.cke;
	assign o_ddr_cs  = cmd_q.cs;
	assign {o_ddr_ras, o_ddr_cas, o_ddr_we} = cmd_q.cmd;
	assign o_ddr_ba  = cmd_q.ba;
	assign o_ddr_a   = cmd_q.addr;
	assign o_ddr_dm  = '0;

	// --------------------------------------------------
	// Write path
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		dq_even_q <= i_dq_write_even;
		dq_odd_q  <= i_dq_write_odd;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			dq_oe <= 1'b0;
		end else begin
			dq_oe <= i_dq_write_next_en;
		end
	end

	// Opens a quarter cycle ahead of the data for the preamble
	always_ff @(negedge i_clk90) begin
		if (i_reset) begin
			dqs_oe <= 1'b0;
		end else begin
			dqs_oe <= i_dqs_write_next_en;
		end
	end

	// Even beat in the high phase, odd beat in the low phase
	assign dq_out = i_clk ? dq_even_q : dq_odd_q;

	assign io_ddr_dq  = dq_oe ? dq_out : 'z;
	// Strobe edges land in the middle of each beat
	assign io_ddr_dqs = dqs_oe ? {DQS_W{i_clk90}} : 'z;

	// --------------------------------------------------
	// Read capture
	// --------------------------------------------------
	always_ff @(negedge i_clk) begin
		rd_even_neg <= io_ddr_dq;
	end

	always_ff @(posedge i_clk) begin
		o_dq_read_even <= rd_even_neg;
		o_dq_read_odd  <= io_ddr_dq;
	end

	a_no_drive_on_read: assert property (@(posedge i_clk) disable iff (i_reset)
		(!cmd_q.cs && cmd_q.cmd == READ) |-> (!dq_oe && !dqs_oe) [*(`DDR_CAS_LAT + 1)])
		else $error("DQ or DQS driven during read burst");

endmodule

/* hw/ddr_sdram_top.sv */
`timescale 1ns/10ps
`include "ddr_sdram_params.svh"

module ddr_sdram_top (
	input  logic                       i_clk,
	input  logic                       i_clk90,
	input  logic                       i_reset,
	input  logic                       i_req0,
	input  host_pkg::host_req_t        i_req_data0,
	output logic                       o_done0,
	output logic                       o_rd_valid0,
	output logic [31:0]                o_rd_data0,
	input  logic                       i_req1,
	input  host_pkg::host_req_t        i_req_data1,
	output logic                       o_done1,
	output logic                       o_rd_valid1,
	output logic [31:0]                o_rd_data1,
	output logic                       o_ddr_ck_p,
	output logic                       o_ddr_ck_n,
	output logic                       o_ddr_cke,
	output logic                       o_ddr_cs,
	output logic                       o_ddr_ras,
	output logic                       o_ddr_cas,
	output logic                       o_ddr_we,
	output logic [`DDR_BA_WIDTH-1:0]   o_ddr_ba,
	output logic [`DDR_ROW_WIDTH-1:0]  o_ddr_a,
	output logic [`DDR_DQ_WIDTH/8-1:0] o_ddr_dm,
	inout  wire  [`DDR_DQ_WIDTH-1:0]   io_ddr_dq,
	inout  wire  [`DDR_DQ_WIDTH/8-1:0] io_ddr_dqs
);
	import ddr_sdram_pkg::*;
	import host_pkg::*;

	logic                     arb_start;
	host_req_t                arb_req;
	port_sel_e                arb_port;
	logic                     ctrl_ready;
	host_rsp_t                rsp;
	ddr_cmd_t                 cmd;
	logic                     dq_write_next_en;
	logic                     dqs_write_next_en;
	logic [`DDR_DQ_WIDTH-1:0] dq_write_even;
	logic [`DDR_DQ_WIDTH-1:0] dq_write_odd;
	logic [`DDR_DQ_WIDTH-1:0] dq_read_even;
	logic [`DDR_DQ_WIDTH-1:0] dq_read_odd;

	host_arbiter u_arbiter (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_req0      (i_req0),
		.i_req1      (i_req1),
		.i_req_data0 (i_req_data0),
		.i_req_data1 (i_req_data1),
		.i_ready     (ctrl_ready),
		.i_done      (rsp.done),
		.o_start     (arb_start),
		.o_req       (arb_req),
		.o_port      (arb_port)
	);

	ddr_sdram_ctrl u_ctrl (
		.i_clk               (i_clk),
		.i_reset             (i_reset),
		.i_start             (arb_start),
		.i_req               (arb_req),
		.o_ready             (ctrl_ready),
		.o_done              (rsp.done),
		.o_rd_valid          (rsp.rd_valid),
		.o_rd_data           (rsp.rd_data),
		.o_cmd               (cmd),
		.o_dq_write_next_en  (dq_write_next_en),
		.o_dqs_write_next_en (dqs_write_next_en),
		.o_dq_write_even     (dq_write_even),
		.o_dq_write_odd      (dq_write_odd),
		.i_dq_read_even      (dq_read_even),
		.i_dq_read_odd       (dq_read_odd)
	);

	ddr_sdram_io u_io (
		.i_clk               (i_clk),
		.i_clk90             (i_clk90),
		.i_reset             (i_reset),
		.i_cmd               (cmd),
		.i_dq_write_next_en  (dq_write_next_en),
		.i_dqs_write_next_en (dqs_write_next_en),
		.i_dq_write_even     (dq_write_even),
		.i_dq_write_odd      (dq_write_odd),
		.o_dq_read_even      (dq_read_even),
		.o_dq_read_odd       (dq_read_odd),
		.o_ddr_ck_p          (o_ddr_ck_p),
		.o_ddr_ck_n          (o_ddr_ck_n),
		.o_ddr_cke           (o_ddr_cke),
		.o_ddr_cs            (o_ddr_cs),
		.o_ddr_ras           (o_ddr_ras),
		.o_ddr_cas           (o_ddr_cas),
		.o_ddr_we            (o_ddr_we),
		.o_ddr_ba            (o_ddr_ba),
		.o_ddr_a             (o_ddr_a),
		.o_ddr_dm            (o_ddr_dm),
		.io_ddr_dq           (io_ddr_dq),
		.io_ddr_dqs          (io_ddr_dqs)
	);

	// Completion goes back to the port held by the arbiter
	always_comb begin
		o_done0     = 1'b0;
		o_rd_valid0 = 1'b0;
		o_done1     = 1'b0;
		o_rd_valid1 = 1'b0;
		if (arb_port == PORT1) begin
			o_done1     = rsp.done;
			o_rd_valid1 = rsp.rd_valid;
		end else begin
			o_done0     = rsp.done;
			o_rd_valid0 = rsp.rd_valid;
		end
	end

	// Shared read bus, qualified by each port's valid
	assign o_rd_data0 = rsp.rd_data;
	assign o_rd_data1 = rsp.rd_data;

endmodule

/* tb/ddr_sdram_model.sv */
`timescale 1ns/10ps
`include "ddr_sdram_params.svh"

module ddr_sdram_model (
	input  logic                       i_ck_p,
	input  logic                       i_ck_n,
	input  logic                       i_cke,
	input  logic                       i_cs,
	input  logic                       i_ras,
	input  logic                       i_cas,
	input  logic                       i_we,
	input  logic [`DDR_BA_WIDTH-1:0]   i_ba,
	input  logic [`DDR_ROW_WIDTH-1:0]  i_a,
	input  logic [`DDR_DQ_WIDTH/8-1:0] i_dm,
	inout  wire  [`DDR_DQ_WIDTH-1:0]   io_dq,
	inout  wire  [`DDR_DQ_WIDTH/8-1:0] io_dqs
);
	import ddr_sdram_pkg::*;

	// Beats folded into a small array: bank, low row bits, low col bits, beat
	logic [`DDR_DQ_WIDTH-1:0]  mem [0:1023];
	logic [`DDR_ROW_WIDTH-1:0] open_row [0:3];
	logic [3:0]                row_open;
	logic [`DDR_DQ_WIDTH-1:0]  dq_drive;
	logic                      dq_oe;
	ddr_cmd_e                  cmd;
	int                        refresh_count;
	int                        protocol_errors;
	int                        idx;

	assign cmd    = ddr_cmd_e'({i_ras, i_cas, i_we});
	assign io_dq  = dq_oe ? dq_drive : 'z;
	assign io_dqs = 'z;

	function automatic int beat_index(logic [1:0] ba, logic [`DDR_ROW_WIDTH-1:0] row,
	                                  logic [`DDR_COL_WIDTH-1:0] col);
		return {ba, row[3:0], col[2:0], 1'b0};
	endfunction

	initial begin
		dq_oe           = 1'b0;
		dq_drive        = '0;
		row_open        = '0;
		refresh_count   = 0;
		protocol_errors = 0;
	end

	// CAS latency 2, then even beat in the high phase and odd in the low phase
	task automatic send_read(input int base);
		@(posedge i_ck_p);
		@(posedge i_ck_p);
		#1 dq_drive = mem[base];
		dq_oe = 1'b1;
		@(posedge i_ck_n);
		#1 dq_drive = mem[base + 1];
		@(posedge i_ck_p);
		#1 dq_oe = 1'b0;
	endtask

	// Beats sampled in the middle of each half cycle
	task automatic take_write(input int base);
		@(posedge i_ck_p);
		#1;
		// DQS still low ahead of its mid-beat edge, and no masking
		if (io_dqs !== '0 || i_dm !== '0) begin
			protocol_errors++;
		end
		#1.5 mem[base] = io_dq;
		#1.5;
		if (io_dqs !== '1) begin
			protocol_errors++;
		end
		@(posedge i_ck_n);
		#2.5 mem[base + 1] = io_dq;
	endtask

	// Command pins change on the rising edge, decode in mid cycle
	always @(posedge i_ck_n) begin
		if (!i_cs && i_cke) begin
			case (cmd)
				ACTIVE: begin
					if (row_open[i_ba]) begin
						protocol_errors++;
					end
					row_open[i_ba] = 1'b1;
					open_row[i_ba] = i_a;
				end
				READ, WRITE: begin
					if (!row_open[i_ba]) begin
						protocol_errors++;
						$display("Model: access to closed bank %0d at %0t", i_ba, $time);
					end
					idx = beat_index(i_ba, open_row[i_ba], i_a[`DDR_COL_WIDTH-1:0]);
					if (i_a[10]) begin
						row_open[i_ba] = 1'b0;
					end
					if (cmd == READ) begin
						fork
							send_read(idx);
						join_none
					end else begin
						fork
							take_write(idx);
						join_none
					end
				end
				PRECHARGE: row_open[i_ba] = 1'b0;
				REFRESH: begin
					refresh_count++;
					if (row_open != '0) begin
						protocol_errors++;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

/* tb/tb_ddr_sdram_top.sv */
`timescale 1ns/10ps
`include "ddr_sdram_params.svh"

module tb_ddr_sdram_top;
	import host_pkg::*;

	logic                       i_clk;
	logic                       i_clk90;
	logic                       i_reset;
	logic                       i_req0;
	logic                       i_req1;
	host_req_t                  i_req_data0;
	host_req_t                  i_req_data1;
	logic                       o_done0;
	logic                       o_done1;
	logic                       o_rd_valid0;
	logic                       o_rd_valid1;
	logic [31:0]                o_rd_data0;
	logic [31:0]                o_rd_data1;
	logic                       ck_p;
	logic                       ck_n;
	logic                       cke;
	logic                       cs;
	logic                       ras;
	logic                       cas;
	logic                       we;
	logic [`DDR_BA_WIDTH-1:0]   ba;
	logic [`DDR_ROW_WIDTH-1:0]  a;
	logic [`DDR_DQ_WIDTH/8-1:0] dm;
	wire  [`DDR_DQ_WIDTH-1:0]   dq;
	wire  [`DDR_DQ_WIDTH/8-1:0] dqs;

	// Access table loaded from the data file
	int          n_lines;
	int          l_group [0:63];
	int          l_port [0:63];
	int          l_wr [0:63];
	host_addr_t  l_addr [0:63];
	logic [31:0] l_data [0:63];
	int          l_gap [0:63];
	int          exp_done [0:1];
	int          exp_rv [0:1];
	int          done_cnt [0:1];
	int          rv_cnt [0:1];
	int          done_order [$];
	int          error_count;
	int          cycle_limit;
	bit          loaded;

	ddr_sdram_top uut (
		.i_clk(i_clk), .i_clk90(i_clk90), .i_reset(i_reset),
		.i_req0(i_req0), .i_req_data0(i_req_data0), .o_done0(o_done0),
		.o_rd_valid0(o_rd_valid0), .o_rd_data0(o_rd_data0),
		.i_req1(i_req1), .i_req_data1(i_req_data1), .o_done1(o_done1),
		.o_rd_valid1(o_rd_valid1), .o_rd_data1(o_rd_data1),
		.o_ddr_ck_p(ck_p), .o_ddr_ck_n(ck_n), .o_ddr_cke(cke), .o_ddr_cs(cs),
		.o_ddr_ras(ras), .o_ddr_cas(cas), .o_ddr_we(we), .o_ddr_ba(ba),
		.o_ddr_a(a), .o_ddr_dm(dm), .io_ddr_dq(dq), .io_ddr_dqs(dqs)
	);

	ddr_sdram_model u_model (
		.i_ck_p(ck_p), .i_ck_n(ck_n), .i_cke(cke), .i_cs(cs), .i_ras(ras),
		.i_cas(cas), .i_we(we), .i_ba(ba), .i_a(a), .i_dm(dm),
		.io_dq(dq), .io_dqs(dqs)
	);

	always #5 i_clk = ~i_clk;

	always begin
		#2.5;
		forever #5 i_clk90 = ~i_clk90;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Holds the request until done, then checks the response
	task automatic run_access(input int line);
		host_req_t r;
		int        p;
		logic      done;
		p       = l_port[line];
		r.wr    = l_wr[line][0];
		r.addr  = l_addr[line];
		r.wdata = l_wr[line] ? l_data[line] : '0;
		if (p == 0) begin
			i_req_data0 = r;
			i_req0      = 1'b1;
		end else begin
			i_req_data1 = r;
			i_req1      = 1'b1;
		end
		done = 1'b0;
		while (!done) begin
			@(negedge i_clk);
			done = (p == 0) ? o_done0 : o_done1;
		end
		done_order.push_back(p);
		if (p == 0) begin
			check_value("o_rd_valid0", !l_wr[line], o_rd_valid0);
			if (!l_wr[line]) check_value("o_rd_data0", l_data[line], o_rd_data0);
			i_req0 = 1'b0;
		end else begin
			check_value("o_rd_valid1", !l_wr[line], o_rd_valid1);
			if (!l_wr[line]) check_value("o_rd_data1", l_data[line], o_rd_data1);
			i_req1 = 1'b0;
		end
	endtask

	// Count completions per port
	always @(negedge i_clk) begin
		if (!i_reset) begin
			if (o_done0) done_cnt[0]++;
			if (o_done1) done_cnt[1]++;
			if (o_rd_valid0) begin
				rv_cnt[0]++;
				check_value("o_done0", 1, o_done0);
			end
			if (o_rd_valid1) begin
				rv_cnt[1]++;
				check_value("o_done1", 1, o_done1);
			end
		end
	end

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------
	initial begin
		wait (loaded);
		repeat (cycle_limit) @(posedge i_clk);
		$display("Timeout: accesses did not finish within %0d cycles", cycle_limit);
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		int          fd;
		int          n;
		int          i;
		int          j;
		int          last_winner;
		int          ref_before;
		int          g;
		int          p;
		int          w;
		int          gap;
		logic [31:0] bank;
		logic [31:0] row;
		logic [31:0] col;
		logic [31:0] data;
		string       line;
		i_clk       = 0;
		i_clk90     = 0;
		i_reset     = 1;
		i_req0      = 0;
		i_req1      = 0;
		i_req_data0 = '0;
		i_req_data1 = '0;
		n_lines     = 0;
		error_count = 0;
		loaded      = 0;
		cycle_limit = 1000;
		exp_done    = '{0, 0};
		exp_rv      = '{0, 0};
		done_cnt    = '{0, 0};
		rv_cnt      = '{0, 0};
		fd = $fopen("tb/tb_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tb/tb_input.txt");
			$display("Simulation failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %d %h %h %h %h %d", g, p, w, bank, row, col, data, gap);
				if (n == 8) begin
					l_group[n_lines] = g;
					l_port[n_lines]  = p;
					l_wr[n_lines]    = w;
					l_addr[n_lines]  = '{bank[1:0], row[`DDR_ROW_WIDTH-1:0],
					                     col[`DDR_COL_WIDTH-1:0]};
					l_data[n_lines]  = data;
					l_gap[n_lines]   = gap;
					exp_done[p]++;
					if (!w) exp_rv[p]++;
					cycle_limit += 40 + gap;
					n_lines++;
				end
			end
		end
		$fclose(fd);
		loaded = 1;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 0;
		last_winner = 1;
		i = 0;
		while (i < n_lines) begin
			j = i + 1;
			while (j < n_lines && l_group[j] == l_group[i]) j++;
			if (j - i == 2) begin
				// Both ports raise in the same cycle
				fork
					run_access(i);
					run_access(i + 1);
				join
				// The tie goes to the last loser, so the previous winner ends the pair
				check_value("first_done_port", (last_winner == 0) ? 1 : 0,
				            done_order[done_order.size() - 2]);
			end else begin
				run_access(i);
				last_winner = l_port[i];
			end
			gap = l_gap[j - 1];
			ref_before = u_model.refresh_count;
			repeat (gap) @(negedge i_clk);
			if (gap > `DDR_REFRESH_INTERVAL) begin
				check_value("refresh_count_ok", 1,
				            (u_model.refresh_count - ref_before) >= gap / `DDR_REFRESH_INTERVAL);
			end
			i = j;
		end
		repeat (4) @(negedge i_clk);
		check_value("done_count0", exp_done[0], done_cnt[0]);
		check_value("done_count1", exp_done[1], done_cnt[1]);
		check_value("rd_valid_count0", exp_rv[0], rv_cnt[0]);
		check_value("rd_valid_count1", exp_rv[1], rv_cnt[1]);
		check_value("protocol_errors", 0, u_model.protocol_errors);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1);
		end
	end

endmodule

/* tb/tb_input.txt */
# group port wr(1)/rd(0) bank row col data(write or expected read) idle_gap
# lines with the same group raise both ports in the same cycle
1 0 1 0 0001 004 a5a51234 2
2 0 0 0 0001 004 a5a51234 2
3 0 1 1 0002 001 11112222 0
4 1 1 2 0003 002 33334444 0
5 1 0 1 0002 001 11112222 0
6 0 0 2 0003 002 33334444 0
7 0 1 3 0005 003 deadbeef 0
7 1 1 1 0006 005 cafef00d 0
8 0 0 1 0006 005 cafef00d 0
8 1 0 3 0005 003 deadbeef 450
9 0 0 0 0001 004 a5a51234 0
10 1 0 3 0005 003 deadbeef 0
11 1 1 0 0004 000 0badf00d 5
12 0 0 0 0004 000 0badf00d 0

/* vlog.f */
+incdir+common
common/ddr_sdram_pkg.sv
common/host_pkg.sv
hw/host_arbiter.sv
ddr_sdram/ddr_sdram_ctrl.sv
ddr_sdram/ddr_sdram_io.sv
hw/ddr_sdram_top.sv
tb/ddr_sdram_model.sv
tb/tb_ddr_sdram_top.sv
